/* logic/pwrCtrlTop.sv */
`default_nettype none

module pwrCtrlTop #(
  parameter int unsigned SettleCycles = 28
) (
  input  wire                 pclk27,
  input  wire                 nprst27,
  input  wire pwrPkg::regReqS regReq,
  output pwrPkg::wordT        rdData,
  output logic                rdValid,
  output logic                lpActive
);

  import pwrPkg::*;

  // Register block to sequencer
  logic    lpReq;
  logic    setStatus;
  logic    clrStatus;
  // Register block to domain
  logic    domWrStb;
  wordT    domWrData;
  // Domain back to the register block
  wordT    domData;
  wordT    domCount;
  // Sequencer to domain
  pwrCtrlS ctrl;

  // --------------------------------------------------
  // Register block
  // --------------------------------------------------

  pwrRegs uRegs (
    .pclk27    (pclk27),
    .nprst27   (nprst27),
    .regReq    (regReq),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .domData   (domData),
    .domCount  (domCount),
    .lpReq     (lpReq),
    .domWrStb  (domWrStb),
    .domWrData (domWrData),
    .rdData    (rdData),
    .rdValid   (rdValid),
    .lpActive  (lpActive)
  );

  // --------------------------------------------------
  // Sequencer and controlled domain
  // --------------------------------------------------

  pwrSequencer #(
    .SettleCycles (SettleCycles)
  ) uSequencer (
    .pclk27    (pclk27),
    .nprst27   (nprst27),
    .lpReq     (lpReq),
    .ctrl      (ctrl),
    .setStatus (setStatus),
    .clrStatus (clrStatus)
  );

  retentionDomain uDomain (
    .pclk27    (pclk27),
    .nprst27   (nprst27),
    .ctrl      (ctrl),
    .domWrStb  (domWrStb),
    .domWrData (domWrData),
    .domData   (domData),
    .domCount  (domCount)
  );

endmodule

`default_nettype wire

/* logic/pwrPkg.sv */
`default_nettype none

package pwrPkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------

  // Data word of the register port and the domain
  typedef logic [15:0] wordT;

  // Register address
  typedef logic [1:0] regAddrT;

  // Settle counter used in PwrOn2
  localparam int settleWidthC = 6;
  typedef logic [settleWidthC-1:0] settleCntT;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------

  // Bit 0 is the low-power request
  localparam regAddrT AddrCtrl = 2'd0;
  // Bit 0 is low-power status, bit 1 is domain powered
  localparam regAddrT AddrStatus = 2'd1;
  // Retained word of the domain
  localparam regAddrT AddrData = 2'd2;
  // Non-retained activity counter
  localparam regAddrT AddrCount = 2'd3;

  // --------------------------------------------------
  // Bundles
  // --------------------------------------------------

  // One register access, stb is a single-cycle strobe
  typedef struct packed {
    logic    stb;
    logic    write;
    regAddrT addr;
    wordT    wdata;
  } regReqS;

  // Control from the sequencer to the switchable domain
  typedef struct packed {
    logic gateClk;
    logic isolate;
    logic saveEdge;
    logic restoreEdge;
    logic pwr1On;
    logic pwr2On;
    logic rstnNonSrpg;
  } pwrCtrlS;

  // Power-shutoff sequence, shutdown first and then power-up
  typedef enum logic [3:0] {
    Idle,
    ClkOff,
    WaitGate,
    Isolate,
    SaveEdge,
    PrePwrOff,
    PwrOff,
    PwrOn1,
    PwrOn2,
    RestoreEdge,
    WaitRestore,
    DeIsolate,
    ClkOn,
    WaitClk,
    RstClr
  } seqStateT;

endpackage

`default_nettype wire

/* logic/pwrRegs.sv */
`default_nettype none

module pwrRegs (
  input  wire                pclk27,
  input  wire                nprst27,
  // Register port from outside
  input  wire pwrPkg::regReqS regReq,
  // Status strobes from the sequencer
  input  wire                setStatus,
  input  wire                clrStatus,
  // Values returned by the domain
  input  wire pwrPkg::wordT  domData,
  input  wire pwrPkg::wordT  domCount,
  // To the sequencer
  output logic               lpReq,
  // Domain write path
  output logic               domWrStb,
  output pwrPkg::wordT       domWrData,
  // Read return
  output pwrPkg::wordT       rdData,
  output logic               rdValid,
  output logic               lpActive
);

  import pwrPkg::*;

  logic lpReqR;
  logic statusR;
  logic ctrlWr;
  logic rdStb;
  wordT rdMux;

  // --------------------------------------------------
  // Request decode
  // --------------------------------------------------

  assign ctrlWr = regReq.stb & regReq.write & (regReq.addr == AddrCtrl);
  assign rdStb = regReq.stb & ~regReq.write;

  // Data writes go straight to the domain, which decides whether to take them
  assign domWrStb = regReq.stb & regReq.write & (regReq.addr == AddrData);
  assign domWrData = regReq.wdata;

  // --------------------------------------------------
  // Control and status bits
  // --------------------------------------------------

  // Low-power request, software owned
  always_ff @(posedge pclk27 or negedge nprst27)
  begin
    if (!nprst27)
      lpReqR <= 1'b0;
    else if (ctrlWr)
      lpReqR <= regReq.wdata[0];
  end

  // Status, set on shutdown start and cleared at the end of power-up
  always_ff @(posedge pclk27 or negedge nprst27)
  begin
    if (!nprst27)
      statusR <= 1'b0;
    else if (setStatus)
      statusR <= 1'b1;
    else if (clrStatus)
      statusR <= 1'b0;
  end

  assign lpReq = lpReqR;
  assign lpActive = statusR;

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------

  always_comb
  begin
    case (regReq.addr)
      AddrCtrl:   rdMux = {15'd0, lpReqR};
      // Domain is live whenever no power cycle is in progress
      AddrStatus: rdMux = {14'd0, ~statusR, statusR};
      AddrData:   rdMux = domData;
      default:    rdMux = domCount;
    endcase
  end

  // Valid strobe one cycle after the read request
  always_ff @(posedge pclk27 or negedge nprst27)
  begin
    if (!nprst27)
      rdValid <= 1'b0;
    else
      rdValid <= rdStb;
  end

  // Read data is held until the next read
  always_ff @(posedge pclk27)
  begin
    if (rdStb)
      rdData <= rdMux;
  end

endmodule

`default_nettype wire

/* logic/pwrSequencer.sv */
`default_nettype none

module pwrSequencer #(
  parameter int unsigned SettleCycles = 28
) (
  input  wire             pclk27,
  input  wire             nprst27,
  // Low-power request from the register block
  input  wire             lpReq,
  // Domain control, all registered
  output pwrPkg::pwrCtrlS ctrl,
  // Status strobes back to the register block
  output logic            setStatus,
  output logic            clrStatus
);

  import pwrPkg::*;

  // Both switches on, clock running, no isolation
  localparam pwrCtrlS CtrlReset = '{
    gateClk:     1'b0,
    isolate:     1'b0,
    saveEdge:    1'b0,
    restoreEdge: 1'b0,
    pwr1On:      1'b1,
    pwr2On:      1'b1,
    rstnNonSrpg: 1'b1
  };

  seqStateT  state;
  seqStateT  nextState;
  settleCntT settleCnt;
  logic      settleDone;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------

  assign settleDone = (settleCnt == '0);

  always_comb
  begin
    nextState = state;
    case (state)
      // Start shutdown once software asks for it
      Idle:
        if (lpReq)
          nextState = ClkOff;
      ClkOff:
        nextState = WaitGate;
      // Let the gated clock settle before clamping
      WaitGate:
        nextState = Isolate;
      Isolate:
        nextState = SaveEdge;
      SaveEdge:
        nextState = PrePwrOff;
      PrePwrOff:
        nextState = PwrOff;
      // Stay off until the request is withdrawn
      PwrOff:
        if (!lpReq)
          nextState = PwrOn1;
      PwrOn1:
        nextState = PwrOn2;
      // Second switch on, wait for the rail
      PwrOn2:
        if (settleDone)
          nextState = RestoreEdge;
      RestoreEdge:
        nextState = WaitRestore;
      WaitRestore:
        nextState = DeIsolate;
      DeIsolate:
        nextState = ClkOn;
      ClkOn:
        nextState = WaitClk;
      // One cycle of running clock before the reset lifts
      WaitClk:
        nextState = RstClr;
      RstClr:
        nextState = Idle;
      default:
        nextState = Idle;
    endcase
  end

  always_ff @(posedge pclk27 or negedge nprst27)
  begin
    if (!nprst27)
      state <= Idle;
    else
      state <= nextState;
  end

  // --------------------------------------------------
  // Settle counter
  // --------------------------------------------------

  // Loaded on the way into PwrOn2 so that the state lasts SettleCycles
  always_ff @(posedge pclk27 or negedge nprst27)
  begin
    if (!nprst27)
      settleCnt <= '0;
    else if (nextState == PwrOn2 && state != PwrOn2)
      settleCnt <= settleCntT'(SettleCycles - 1);
    else if (state == PwrOn2 && !settleDone)
      settleCnt <= settleCnt - 1'b1;
  end

  // --------------------------------------------------
  // Domain control, one cycle behind the decision
  // --------------------------------------------------

  always_ff @(posedge pclk27 or negedge nprst27)
  begin
    if (!nprst27)
      ctrl <= CtrlReset;
    else
    begin
      // Clock stays gated from ClkOff until ClkOn
      ctrl.gateClk <= !(nextState inside {Idle, ClkOn, WaitClk, RstClr});
      // Clamp covers the whole time the outputs may be invalid
      ctrl.isolate <= nextState inside {Isolate, SaveEdge, PrePwrOff, PwrOff,
                                        PwrOn1, PwrOn2, RestoreEdge, WaitRestore};
      ctrl.saveEdge <= (nextState == SaveEdge);
      ctrl.restoreEdge <= (nextState == RestoreEdge);
      // Switch 2 comes back one cycle after switch 1
      ctrl.pwr1On <= (nextState != PwrOff);
      ctrl.pwr2On <= !(nextState inside {PwrOff, PwrOn1});
      // Non-retained flops held in reset while power is unreliable
      ctrl.rstnNonSrpg <= !(nextState inside {PwrOff, PwrOn1, PwrOn2, RestoreEdge,
                                              WaitRestore, DeIsolate, ClkOn, WaitClk});
    end
  end

  // --------------------------------------------------
  // Status strobes
  // --------------------------------------------------

  assign setStatus = (nextState == ClkOff);
  assign clrStatus = (state == RstClr);

endmodule

`default_nettype wire

/* logic/retentionDomain.sv */
`default_nettype none

module retentionDomain (
  input  wire                 pclk27,
  input  wire                 nprst27,
  // Sequencer control bundle
  input  wire pwrPkg::pwrCtrlS ctrl,
  // Write path from the register block
  input  wire                 domWrStb,
  input  wire pwrPkg::wordT   domWrData,
  // Observed values
  output pwrPkg::wordT        domData,
  output pwrPkg::wordT        domCount
);

  import pwrPkg::*;

  logic powered;
  logic clkRun;
  logic wrAccept;
  logic cntRstN;
  wordT dataR;
  wordT shadowR;
  wordT cntR;

  // --------------------------------------------------
  // Domain conditions
  // --------------------------------------------------

  // Both switches must be closed for the logic to hold state
  assign powered = ctrl.pwr1On & ctrl.pwr2On;
  // Gated clock modelled as an enable on the domain flops
  assign clkRun = ~ctrl.gateClk;
  assign wrAccept = domWrStb & clkRun & powered;

  // Non-retained reset is the chip reset or the sequencer's domain reset
  assign cntRstN = nprst27 & ctrl.rstnNonSrpg;

  // --------------------------------------------------
  // Retained word
  // --------------------------------------------------

  // Functional register, lost when power goes away
  always_ff @(posedge pclk27 or negedge nprst27)
  begin
    if (!nprst27)
      dataR <= '0;
    else if (!powered)
      dataR <= '0;
    else if (ctrl.restoreEdge)
      dataR <= shadowR;
    else if (wrAccept)
      dataR <= domWrData;
  end

  // Shadow on the always-on supply
  always_ff @(posedge pclk27)
  begin
    if (ctrl.saveEdge)
      shadowR <= dataR;
  end

  // --------------------------------------------------
  // Activity counter, not retained
  // --------------------------------------------------

  always_ff @(posedge pclk27 or negedge cntRstN)
  begin
    if (!cntRstN)
      cntR <= '0;
    else if (wrAccept)
      cntR <= cntR + 1'b1;
  end

  // Output clamp
  assign domData = ctrl.isolate ? '0 : dataR;
  assign domCount = cntR;

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# Build with Verilator, run, and decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module pwrCtrlTb -f sources.f -o simv \
  && ./obj_dir/simv | tee sim.log \
  || echo "Build or simulation did not complete"
grep -q "^All tests passed$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sources.f */
logic/pwrPkg.sv
logic/pwrRegs.sv
logic/pwrSequencer.sv
logic/retentionDomain.sv
logic/pwrCtrlTop.sv
verification/pwrSeq_chk.sv
verification/pwrCtrlTb.sv

/* verification/pwrCtrlTb.sv */
`default_nettype none

module pwrCtrlTb;

  import pwrPkg::*;

  localparam int unsigned SettleCycles = 28;
  localparam int MaxVectors = 64;
  localparam int ReadTimeout = 4;
  localparam string VectorFile = "verification/pwrCtrl_vectors.txt";

  logic   pclk27;
  logic   nprst27;
  regReqS regReq;
  wordT   rdData;
  logic   rdValid;
  logic   lpActive;

  // --------------------------------------------------
  // Vector table and counters
  // --------------------------------------------------

  logic [127:0] vecName [MaxVectors];
  logic [7:0]   vecOp [MaxVectors];
  regAddrT      vecAddr [MaxVectors];
  wordT         vecData [MaxVectors];
  wordT         vecExp [MaxVectors];
  int vecCount;
  int cycleCount;
  int cycleLimit;
  int errorCount;
  int checkCount;
  int testCount;
  int failedTests;

  pwrCtrlTop #(
    .SettleCycles (SettleCycles)
  ) UUT (
    .pclk27   (pclk27),
    .nprst27  (nprst27),
    .regReq   (regReq),
    .rdData   (rdData),
    .rdValid  (rdValid),
    .lpActive (lpActive)
  );

  // 4-unit clock period
  always #2 pclk27 = ~pclk27;

  // Run limit
  always @(posedge pclk27)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout after %0d cycles, the vector run did not finish", cycleCount);
      $display("Some tests failed");
      $finish;
    end
  end

  // Reads every non-comment line of the vector file into the table
  task automatic loadVectors();
    int fd;
    int fields;
    string line;
    logic [127:0] name;
    logic [7:0]   op;
    logic [31:0]  addr;
    logic [31:0]  data;
    logic [31:0]  expVal;
    vecCount = 0;
    fd = $fopen(VectorFile, "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file %s", VectorFile);
      errorCount++;
      return;
    end
    while (!$feof(fd) && vecCount < MaxVectors)
    begin
      fields = $fgets(line, fd);
      // Blank lines and # comments carry no operation
      if (fields > 0 && line.len() > 1 && line.getc(0) != "#")
      begin
        fields = $sscanf(line, "%s %c %h %h %h", name, op, addr, data, expVal);
        if (fields == 5)
        begin
          vecName[vecCount] = name;
          vecOp[vecCount] = op;
          vecAddr[vecCount] = regAddrT'(addr);
          vecData[vecCount] = wordT'(data);
          vecExp[vecCount] = wordT'(expVal);
          vecCount++;
        end
        else
        begin
          $display("Vector line could not be parsed: %s", line);
          errorCount++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Reset, a few cycles per operation, idle counts and four full power cycles per shutdown
  function automatic int computeLimit();
    int total;
    int i;
    total = 3 + 50;
    for (i = 0; i < vecCount; i++)
    begin
      if (vecOp[i] == "i")
        total += int'(vecData[i]);
      else
        total += 6;
      if (vecOp[i] == "w" && vecAddr[i] == AddrCtrl && vecData[i][0])
        total += 4 * (13 + int'(SettleCycles));
    end
    return total;
  endfunction

  // --------------------------------------------------
  // Register port operations starting on a falling edge
  // --------------------------------------------------

  task automatic writeReg(input regAddrT addr, input wordT data);
    regReq.stb = 1'b1;
    regReq.write = 1'b1;
    regReq.addr = addr;
    regReq.wdata = data;
    @(negedge pclk27);
    regReq = '0;
  endtask

  task automatic readCheck(input logic [127:0] name, input regAddrT addr, input wordT expVal);
    int waited;
    regReq.stb = 1'b1;
    regReq.write = 1'b0;
    regReq.addr = addr;
    regReq.wdata = '0;
    @(negedge pclk27);
    regReq = '0;
    waited = 1;
    // Valid strobe is expected one cycle after the request
    while (!rdValid && waited < ReadTimeout)
    begin
      @(negedge pclk27);
      waited++;
    end
    checkCount++;
    if (!rdValid)
    begin
      $display("Read of address %0d in test %0s returned no valid data", addr, name);
      errorCount++;
    end
    else if (rdData !== expVal)
    begin
      $display("Mismatch in %0s: expected %h, actual %h", name, expVal, rdData);
      errorCount++;
    end
    // The low-power output mirrors status bit 0
    if (addr == AddrStatus && lpActive !== expVal[0])
    begin
      $display("Mismatch in %0s lpActive: expected %b, actual %b",
               name, expVal[0], lpActive);
      errorCount++;
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial
  begin
    int i;
    int testErrors;
    pclk27 = 1'b0;
    nprst27 = 1'b0;
    regReq = '0;
    cycleCount = 0;
    cycleLimit = 1000;
    errorCount = 0;
    checkCount = 0;
    testCount = 0;
    failedTests = 0;
    loadVectors();
    cycleLimit = computeLimit();
    repeat (3) @(posedge pclk27);
    @(negedge pclk27);
    nprst27 = 1'b1;
    @(negedge pclk27);
    testErrors = errorCount;
    for (i = 0; i < vecCount; i++)
    begin
      case (vecOp[i])
        "w": writeReg(vecAddr[i], vecData[i]);
        "r": readCheck(vecName[i], vecAddr[i], vecExp[i]);
        "i": repeat (vecData[i]) @(negedge pclk27);
        default:
        begin
          $display("Unknown operation in test %0s", vecName[i]);
          errorCount++;
        end
      endcase
      // A test ends where the next line has another name
      if (i == vecCount - 1 || vecName[i + 1] != vecName[i])
      begin
        testCount++;
        if (errorCount == testErrors)
          $display("Test %0s: ok", vecName[i]);
        else
        begin
          failedTests++;
          $display("Test %0s: %0d errors", vecName[i], errorCount - testErrors);
        end
        testErrors = errorCount;
      end
    end
    if (vecCount == 0)
    begin
      $display("No vectors were run");
      errorCount++;
    end
    $display("Summary: %0d tests, %0d failed, %0d reads checked, %0d errors",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/pwrCtrl_vectors.txt */
# Columns: test name, op (w write, r read, i idle cycles), address, data, expected read (hex)
# Addresses: 0 control, 1 status, 2 data, 3 count; idle uses the data column as a cycle count
resetStatus  r 1 0000 0002
resetCount   r 3 0000 0000
resetData    w 2 5a3c 0000
resetData    r 2 0000 5a3c
resetData    r 3 0000 0001
enterOff     w 0 0001 0000
enterOff     i 0 000a 0000
enterOff     r 1 0000 0001
enterOff     r 0 0000 0001
offClamp     r 2 0000 0000
offDrop      w 2 1234 0000
offDrop      r 2 0000 0000
restore      w 0 0000 0000
restore      i 0 0030 0000
restore      r 1 0000 0002
restore      r 3 0000 0000
restore      r 2 0000 5a3c
restore      r 0 0000 0000
afterRestore w 2 00a5 0000
afterRestore w 2 0f0f 0000
afterRestore r 2 0000 0f0f
afterRestore r 3 0000 0002

/* verification/pwrSeq_chk.sv */
`default_nettype none

module pwrSeqChk (
  input wire                  pclk27,
  input wire                  nprst27,
  input wire pwrPkg::pwrCtrlS ctrl,
  input wire                  setStatus,
  input wire                  clrStatus
);

  // --------------------------------------------------
  // Sequencer ordering rules
  // --------------------------------------------------

  // Status strobes never fight
  setClrApart: assert property (@(posedge pclk27) disable iff (!nprst27)
    !(setStatus && clrStatus))
    else $error("Status set and clear strobes asserted together");

  // Isolation follows the clock gate after the WaitGate cycle
  isoAfterGate: assert property (@(posedge pclk27) disable iff (!nprst27)
    $past(ctrl.gateClk) && !$past(ctrl.gateClk, 2) |=> $rose(ctrl.isolate))
    else $error("Isolation did not follow the clock gate");

  // Both switches open together
  pwrOffTogether: assert property (@(posedge pclk27) disable iff (!nprst27)
    $fell(ctrl.pwr1On) |-> $fell(ctrl.pwr2On))
    else $error("Switch 2 stayed on when switch 1 went off");

  // Switch 2 closes one cycle behind switch 1
  pwr2AfterPwr1: assert property (@(posedge pclk27) disable iff (!nprst27)
    $rose(ctrl.pwr1On) |=> ctrl.pwr2On)
    else $error("Switch 2 not on the cycle after switch 1");

endmodule

bind pwrSequencer pwrSeqChk uSeqChk (
  .pclk27    (pclk27),
  .nprst27   (nprst27),
  .ctrl      (ctrl),
  .setStatus (setStatus),
  .clrStatus (clrStatus)
);

`default_nettype wire
